// ==== rtl/pwm_pkg.sv ====
`default_nettype none

package pwm_pkg;

   // ==============================
   // Widths
   // ==============================

   // UART data byte.
   localparam int BYTE_W = 8;

   // PWM counter, divisor and duty values.
   localparam int CNT_W = 8;

   // ==============================
   // Defaults for the top level
   // ==============================

   localparam int NUM_CH_DEF = 5;

   // 100 MHz clock at 115200 baud.
   localparam int CLKS_PER_BIT_DEF = 868;

   // Command decoder state.
   typedef enum logic [1:0] {
      CMD_IDLE   = 2'd0,
      CMD_PERIOD = 2'd1,
      CMD_DUTY   = 2'd2
   } cmd_state_e;

endpackage

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = pwm_pkg::CLKS_PER_BIT_DEF
) (
   input  wire                         clk,
   input  wire                         nRst,
   input  wire                         rx,
   output logic [pwm_pkg::BYTE_W-1:0]  rx_data,
   output logic                        rx_valid
);

   localparam int TW = $clog2(CLKS_PER_BIT);
   localparam int BW = $clog2(pwm_pkg::BYTE_W);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e      state;
   logic [1:0]     sync;
   logic [TW-1:0]  timer;
   logic [BW-1:0]  bit_idx;
   logic           rx_s;
   logic           half_done;
   logic           bit_done;

   assign rx_s      = sync[1];
   assign half_done = (timer == TW'(CLKS_PER_BIT / 2 - 1));
   assign bit_done  = (timer == TW'(CLKS_PER_BIT - 1));

   // Line idles high.
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         sync <= 2'b11;
      end else begin
         sync <= {sync[0], rx};
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state    <= RX_IDLE;
         timer    <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               timer   <= '0;
               bit_idx <= '0;
               if (!rx_s) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (half_done) begin
                  timer <= '0;
                  // A short glitch is not a start bit.
                  state <= rx_s ? RX_IDLE : RX_DATA;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_done) begin
                  timer <= '0;
                  if (bit_idx == BW'(pwm_pkg::BYTE_W - 1)) begin
                     state <= RX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            default: begin
               if (bit_done) begin
                  state    <= RX_IDLE;
                  rx_valid <= rx_s;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
         endcase
      end
   end

   // LSB first.
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_done) begin
         rx_data <= {rx_s, rx_data[pwm_pkg::BYTE_W-1:1]};
      end
   end

   a_valid_single: assert property (@(posedge clk) disable iff (!nRst)
      rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = pwm_pkg::CLKS_PER_BIT_DEF
) (
   input  wire                         clk,
   input  wire                         nRst,
   input  wire                         tx_start,
   input  wire [pwm_pkg::BYTE_W-1:0]   tx_data,
   output logic                        tx,
   output logic                        tx_busy
);

   localparam int TW      = $clog2(CLKS_PER_BIT);
   localparam int FRAME_W = pwm_pkg::BYTE_W + 2;
   localparam int NW      = $clog2(FRAME_W);

   logic [FRAME_W-1:0] frame;
   logic [TW-1:0]      timer;
   logic [NW-1:0]      bit_cnt;

   assign tx = frame[0];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         frame   <= '1;
         timer   <= '0;
         bit_cnt <= '0;
         tx_busy <= 1'b0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            // Stop bit, data, start bit.
            frame   <= {1'b1, tx_data, 1'b0};
            timer   <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b1;
         end
      end else if (timer == TW'(CLKS_PER_BIT - 1)) begin
         timer <= '0;
         frame <= {1'b1, frame[FRAME_W-1:1]};
         if (bit_cnt == NW'(FRAME_W - 1)) begin
            tx_busy <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         timer <= timer + 1'b1;
      end
   end

   a_no_start_busy: assert property (@(posedge clk) disable iff (!nRst)
      tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== rtl/pwm_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_cmd_decoder #(
   parameter int NUM_CH = pwm_pkg::NUM_CH_DEF
) (
   input  wire                         clk,
   input  wire                         nRst,
   input  wire                         rx_valid,
   input  wire [pwm_pkg::BYTE_W-1:0]   rx_data,
   output logic                        div_load,
   output logic [pwm_pkg::CNT_W-1:0]   div_value,
   output logic [NUM_CH-1:0]           duty_load,
   output logic [pwm_pkg::CNT_W-1:0]   duty_value
);

   localparam int ADDR_W = pwm_pkg::BYTE_W - 1;

   pwm_pkg::cmd_state_e      state;
   logic [ADDR_W-1:0]        addr;
   logic [pwm_pkg::CNT_W-1:0] data_q;

   assign div_value  = data_q;
   assign duty_value = data_q;

   // ==============================
   // Header and data bytes
   // ==============================

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state     <= pwm_pkg::CMD_IDLE;
         addr      <= '0;
         div_load  <= 1'b0;
         duty_load <= '0;
      end else begin
         div_load  <= 1'b0;
         duty_load <= '0;
         if (rx_valid) begin
            case (state)
               pwm_pkg::CMD_IDLE: begin
                  addr  <= rx_data[ADDR_W-1:0];
                  state <= rx_data[pwm_pkg::BYTE_W-1] ? pwm_pkg::CMD_PERIOD
                                                      : pwm_pkg::CMD_DUTY;
               end
               pwm_pkg::CMD_PERIOD: begin
                  div_load <= 1'b1;
                  state    <= pwm_pkg::CMD_IDLE;
               end
               pwm_pkg::CMD_DUTY: begin
                  // Out-of-range address matches no channel.
                  for (int i = 0; i < NUM_CH; i++) begin
                     duty_load[i] <= (addr == ADDR_W'(i));
                  end
                  state <= pwm_pkg::CMD_IDLE;
               end
               default: begin
                  state <= pwm_pkg::CMD_IDLE;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         data_q <= pwm_pkg::CNT_W'(rx_data);
      end
   end

   a_duty_onehot: assert property (@(posedge clk) disable iff (!nRst)
      $onehot0(duty_load));

endmodule

`default_nettype wire

// ==== rtl/pwm_timebase.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_timebase (
   input  wire                         clk,
   input  wire                         nRst,
   input  wire                         div_load,
   input  wire [pwm_pkg::CNT_W-1:0]    div_value,
   output logic [pwm_pkg::CNT_W-1:0]   count
);

   logic [pwm_pkg::CNT_W-1:0] div;
   logic [pwm_pkg::CNT_W-1:0] prescale;
   logic                      step;

   // Clock enable for the counter, every div+1 cycles.
   assign step = (prescale == div);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         div      <= '0;
         prescale <= '0;
      end else if (div_load) begin
         div      <= div_value;
         prescale <= '0;
      end else if (step) begin
         prescale <= '0;
      end else begin
         prescale <= prescale + 1'b1;
      end
   end

   // Wraps modulo 256.
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         count <= '0;
      end else if (step) begin
         count <= count + 1'b1;
      end
   end

   a_count_step: assert property (@(posedge clk) disable iff (!nRst)
      $changed(count) |-> count == pwm_pkg::CNT_W'($past(count) + 1'b1));

endmodule

`default_nettype wire

// ==== rtl/pwm_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_channel (
   input  wire                         clk,
   input  wire                         nRst,
   input  wire                         duty_load,
   input  wire [pwm_pkg::CNT_W-1:0]    duty_value,
   input  wire [pwm_pkg::CNT_W-1:0]    count,
   output logic                        pwm
);

   logic [pwm_pkg::CNT_W-1:0] duty;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         duty <= '0;
      end else if (duty_load) begin
         duty <= duty_value;
      end
   end

   // High while the counter is below the duty value.
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pwm <= 1'b0;
      end else begin
         pwm <= (count < duty);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/uart2pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart2pwm #(
   parameter int CLKS_PER_BIT = pwm_pkg::CLKS_PER_BIT_DEF,
   parameter int NUM_CH       = pwm_pkg::NUM_CH_DEF
) (
   input  wire                 clk,
   input  wire                 nRst,
   input  wire                 rx,
   output logic                tx,
   output logic [NUM_CH-1:0]   pwm
);

   logic [pwm_pkg::BYTE_W-1:0] rx_data;
   logic                       rx_valid;
   logic                       tx_start;
   logic                       tx_busy;
   logic                       div_load;
   logic [pwm_pkg::CNT_W-1:0]  div_value;
   logic [NUM_CH-1:0]          duty_load;
   logic [pwm_pkg::CNT_W-1:0]  duty_value;
   logic [pwm_pkg::CNT_W-1:0]  count;

   // Echo unless the transmitter is still busy.
   assign tx_start = rx_valid & ~tx_busy;

   // ==============================
   // Serial side
   // ==============================

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
      .clk      (clk),
      .nRst     (nRst),
      .rx       (rx),
      .rx_data  (rx_data),
      .rx_valid (rx_valid)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
      .clk      (clk),
      .nRst     (nRst),
      .tx_start (tx_start),
      .tx_data  (rx_data),
      .tx       (tx),
      .tx_busy  (tx_busy)
   );

   pwm_cmd_decoder #(.NUM_CH(NUM_CH)) u_decoder (
      .clk        (clk),
      .nRst       (nRst),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .div_load   (div_load),
      .div_value  (div_value),
      .duty_load  (duty_load),
      .duty_value (duty_value)
   );

   // ==============================
   // PWM side
   // ==============================

   pwm_timebase u_timebase (
      .clk       (clk),
      .nRst      (nRst),
      .div_load  (div_load),
      .div_value (div_value),
      .count     (count)
   );

   for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
      pwm_channel u_channel (
         .clk        (clk),
         .nRst       (nRst),
         .duty_load  (duty_load[i]),
         .duty_value (duty_value),
         .count      (count),
         .pwm        (pwm[i])
      );
   end

endmodule

`default_nettype wire

// ==== test/tb_uart2pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart2pwm;

   localparam int CPB        = 16;
   localparam int NCH        = 5;
   localparam int WAIT_LIMIT = 8192;

   logic            clk;
   logic            nRst;
   logic            rx;
   logic            tx;
   logic [NCH-1:0]  pwm;

   logic [15:0]     lfsr;
   int              exp_duty [NCH];
   int              div_k;

   uart2pwm #(.CLKS_PER_BIT(CPB), .NUM_CH(NCH)) u_uart2pwm (
      .clk  (clk),
      .nRst (nRst),
      .rx   (rx),
      .tx   (tx),
      .pwm  (pwm)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ==============================
   // Helpers
   // ==============================

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         lfsr  = lfsr_next(lfsr);
         value = (value << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      assert (actual == expected) else begin
         $display("[ERROR] %0t ns %s: expected %0d, got %0d", $time, name, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display(">>> FAIL");
      $fatal(1, "Timeout");
   endtask

   // One 8N1 frame, LSB first.
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      @(posedge clk);
      for (int i = 0; i < 10; i++) begin
         rx <= frame[i];
         repeat (CPB) @(posedge clk);
      end
   endtask

   task automatic expect_echo(input logic [7:0] b);
      logic [7:0] got;
      int         n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (tx !== 1'b0 && n < WAIT_LIMIT);
      if (tx !== 1'b0) begin
         stop_on_timeout("the echo start bit on tx");
      end
      // Middle of the start bit.
      repeat (CPB / 2) @(negedge clk);
      check_value("tx start bit", 0, int'(tx));
      for (int i = 0; i < 8; i++) begin
         repeat (CPB) @(negedge clk);
         got[i] = tx;
      end
      repeat (CPB) @(negedge clk);
      check_value("tx stop bit", 1, int'(tx));
      check_value("tx echo byte", int'(b), int'(got));
   endtask

   task automatic send_cmd(input logic [7:0] header, input logic [7:0] data);
      pwm_pkg::cmd_state_e exp_state;
      pwm_pkg::cmd_state_e got_state;
      fork
         send_byte(header);
         expect_echo(header);
      join
      fork
         send_byte(data);
         expect_echo(data);
      join
      exp_state = pwm_pkg::CMD_IDLE;
      got_state = u_uart2pwm.u_decoder.state;
      assert (got_state == exp_state) else begin
         $display("[ERROR] %0t ns decoder state: expected %s, got %s", $time,
                  exp_state.name(), got_state.name());
         $display(">>> FAIL");
         $fatal(1, "Decoder not idle after a command");
      end
   endtask

   task automatic wait_level(input int ch, input logic level, output int n);
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (pwm[ch] !== level && n < WAIT_LIMIT);
      if (pwm[ch] !== level) begin
         stop_on_timeout($sformatf("pwm[%0d] to reach %0b", ch, level));
      end
   endtask

   task automatic measure_pwm(input int ch, output int high, output int period);
      int n;
      int low;
      // The first pulse may be cut short by a reload.
      wait_level(ch, 1'b0, n);
      wait_level(ch, 1'b1, n);
      wait_level(ch, 1'b0, n);
      wait_level(ch, 1'b1, n);
      wait_level(ch, 1'b0, high);
      wait_level(ch, 1'b1, low);
      period = high + low;
   endtask

   task automatic check_channel(input int ch);
      int high;
      int period;
      int span;
      span = 256 * (div_k + 1);
      if (exp_duty[ch] == 0) begin
         for (int i = 0; i < span; i++) begin
            @(negedge clk);
            check_value($sformatf("pwm[%0d]", ch), 0, int'(pwm[ch]));
         end
      end else begin
         measure_pwm(ch, high, period);
         check_value($sformatf("pwm[%0d] high cycles", ch), exp_duty[ch] * (div_k + 1), high);
         check_value($sformatf("pwm[%0d] period", ch), span, period);
      end
   endtask

   task automatic check_all_channels();
      for (int c = 0; c < NCH; c++) begin
         check_channel(c);
      end
   endtask

   // ==============================
   // Tests
   // ==============================

   task automatic test_reset();
      check_value("tx", 1, int'(tx));
      for (int i = 0; i < 300; i++) begin
         @(negedge clk);
         check_value("pwm", 0, int'(pwm));
      end
   endtask

   task automatic test_duty();
      int r;
      for (int c = 0; c < NCH; c++) begin
         take_bits(8, r);
         exp_duty[c] = r % 254 + 1;
         send_cmd(8'(c), 8'(exp_duty[c]));
         check_channel(c);
      end
   endtask

   task automatic test_period();
      int r;
      take_bits(2, r);
      div_k = r + 1;
      // Low header bits carry noise.
      take_bits(7, r);
      send_cmd(8'h80 | 8'(r), 8'(div_k));
      check_all_channels();
   endtask

   task automatic test_bad_address();
      int a;
      int d;
      take_bits(7, a);
      take_bits(8, d);
      a = NCH + a % (128 - NCH);
      send_cmd(8'(a), 8'(d));
      check_all_channels();
   endtask

   task automatic test_extremes();
      exp_duty[0] = 0;
      send_cmd(8'd0, 8'd0);
      check_channel(0);
      exp_duty[1] = 255;
      send_cmd(8'd1, 8'd255);
      check_channel(1);
   endtask

   initial begin
      nRst  = 1'b0;
      rx    = 1'b1;
      lfsr  = 16'd57940;
      div_k = 0;
      for (int c = 0; c < NCH; c++) begin
         exp_duty[c] = 0;
      end
      repeat (3) @(posedge clk);
      nRst <= 1'b1;
      test_reset();
      test_duty();
      test_period();
      test_bad_address();
      test_extremes();
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/pwm_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/pwm_cmd_decoder.sv
rtl/pwm_timebase.sv
rtl/pwm_channel.sv
rtl/uart2pwm.sv
test/tb_uart2pwm.sv

// ==== Bender.yml ====
package:
  name: uart2pwm

sources:
  - rtl/pwm_pkg.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/pwm_cmd_decoder.sv
  - rtl/pwm_timebase.sv
  - rtl/pwm_channel.sv
  - rtl/uart2pwm.sv
  - target: test
    files:
      - test/tb_uart2pwm.sv
